// ==== common/axi_mon_consts.svh ====
// Constants for the AXI4 write-path monitor
// Bus field widths, burst FIFO depth and counter limits
`ifndef AXI_MON_CONSTS_SVH
`define AXI_MON_CONSTS_SVH

// Address width of the monitored slave port
`define AXI_ADDR_W 32

// One strobe bit per byte lane of the 64-bit data bus
`define AXI_STRB_W 8

// AWLEN holds the number of beats minus one
`define AXI_LEN_W 8

// AWSIZE encodes the bytes per beat as a power of two
`define AXI_SIZE_W 3

// Bursts that may wait for their write data at the same time
`define BURST_FIFO_DEPTH 8

// Finished bursts that may wait for their B response
`define MAX_OUTSTANDING 14

// Width of the error and completed-burst counters
`define ERR_CNT_W 16

`endif

// ==== common/axi_mon_pkg.sv ====
// Types shared by the write-path monitor
// Field types, error codes and the beat tracker states
`default_nettype none

`include "axi_mon_consts.svh"

package axi_mon_pkg;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_LEN_W-1:0]  len_t;
    typedef logic [`AXI_SIZE_W-1:0] size_t;
    typedef logic [`AXI_STRB_W-1:0] strb_t;

    // Each code is also the bit position of its sticky flag
    typedef enum logic [2:0] {
        ERR_AW_OVERFLOW = 3'd0,
        ERR_W_NO_AW     = 3'd1,
        ERR_WLAST       = 3'd2,
        ERR_STRB        = 3'd3,
        ERR_B_NO_WRITE  = 3'd4
    } err_code_e;

    // Number of sticky error flags
    localparam int unsigned NUM_ERR = int'(ERR_B_NO_WRITE) + 1;

    // BT_IDLE means the next accepted beat opens a burst
    typedef enum logic {
        BT_IDLE  = 1'b0,
        BT_BURST = 1'b1
    } beat_state_e;

endpackage

`default_nettype wire

// ==== verilog/burst_fifo.sv ====
// Synchronous FIFO for packed burst descriptors
// Circular buffer with read and write pointers and an occupancy count
`timescale 1ns/1ns
`default_nettype none

module burst_fifo #(
    parameter int unsigned DEPTH = 8,
    parameter int unsigned WIDTH = 8
) (
    input  wire              clk_i,
    input  wire              rst_ni,
    input  wire              push_i,
    input  wire              pop_i,
    input  wire  [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Pointers wrap at DEPTH so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // A push and a pop together leave the occupancy unchanged
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // The head entry is visible as soon as it is written
    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    // The owner only pops an entry that exists
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("burst_fifo pop while empty");

    // The owner drops new entries instead of pushing into a full buffer
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("burst_fifo push while full");

endmodule

`default_nettype wire

// ==== write_check/aw_capture.sv ====
// AW channel capture for the write-path monitor
// Queues accepted bursts and presents the descriptor of the current one
`timescale 1ns/1ns
`default_nettype none

`include "axi_mon_consts.svh"

module aw_capture (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                aw_valid_i,
    input  wire                aw_ready_i,
    input  wire  axi_mon_pkg::addr_t aw_addr_i,
    input  wire  axi_mon_pkg::len_t  aw_len_i,
    input  wire  axi_mon_pkg::size_t aw_size_i,
    input  wire                burst_done_i,
    output logic               desc_valid_o,
    output axi_mon_pkg::addr_t desc_addr_o,
    output axi_mon_pkg::len_t  desc_len_o,
    output axi_mon_pkg::size_t desc_size_o,
    output logic               overflow_o
);

    import axi_mon_pkg::*;

    // A descriptor is the address, length and size of one burst
    localparam int unsigned DESC_W = $bits(addr_t) + $bits(len_t) + $bits(size_t);

    logic              aw_hsk;
    logic              fifo_empty;
    logic              fifo_full;
    logic              push;
    logic              pop;
    logic              bypass_done;
    logic [DESC_W-1:0] desc_bus;
    logic [DESC_W-1:0] desc_head;

    // A handshake needs valid and ready high together
    assign aw_hsk   = aw_valid_i && aw_ready_i;
    assign desc_bus = {aw_addr_i, aw_len_i, aw_size_i};

    // Bypass case where a burst arrives on an empty queue and finishes
    // with a single beat in the very same cycle
    assign bypass_done = aw_hsk && fifo_empty && burst_done_i;

    // A burst that finished on arrival needs no queue entry
    // A burst arriving on a full queue is dropped and reported
    assign push       = aw_hsk && !fifo_full && !bypass_done;
    assign pop        = burst_done_i && !fifo_empty;
    assign overflow_o = aw_hsk && fifo_full;

    burst_fifo #(
        .DEPTH (`BURST_FIFO_DEPTH),
        .WIDTH (DESC_W)
    ) i_burst_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push),
        .pop_i   (pop),
        .data_i  (desc_bus),
        .data_o  (desc_head),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    // The queue head is always the oldest burst still waiting for data
    // With an empty queue the bus fields pass straight through, so a
    // tracker beat in the same cycle as its AW handshake sees its burst
    assign desc_valid_o = !fifo_empty || aw_hsk;

    assign {desc_addr_o, desc_len_o, desc_size_o} = fifo_empty ? desc_bus : desc_head;

endmodule

`default_nettype wire

// ==== write_check/beat_tracker.sv ====
// W channel beat tracker for the write-path monitor
// Counts beats per burst and checks WLAST and the exact INCR strobe
`timescale 1ns/1ns
`default_nettype none

`include "axi_mon_consts.svh"

module beat_tracker (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                w_valid_i,
    input  wire                w_ready_i,
    input  wire  axi_mon_pkg::strb_t w_strb_i,
    input  wire                w_last_i,
    input  wire                desc_valid_i,
    input  wire  axi_mon_pkg::addr_t desc_addr_i,
    input  wire  axi_mon_pkg::len_t  desc_len_i,
    input  wire  axi_mon_pkg::size_t desc_size_i,
    output logic               burst_done_o,
    output logic               wlast_err_o,
    output logic               strb_err_o,
    output logic               no_aw_err_o,
    output logic               burst_ok_o
);

    import axi_mon_pkg::*;

    // Bits needed to name a byte lane of the data bus
    localparam int unsigned LANE_W = $clog2(`AXI_STRB_W);

    beat_state_e       state_q;
    beat_state_e       state_d;
    len_t              beat_cnt_q;
    len_t              beat_cnt_d;
    logic [LANE_W-1:0] lane_q;
    logic [LANE_W-1:0] lane_d;
    logic              err_seen_q;
    logic              err_seen_d;

    logic              w_hsk;
    logic              beat_take;
    len_t              beat_idx;
    logic [LANE_W-1:0] cur_lane;
    logic [LANE_W-1:0] next_lane;
    size_t             size_eff;
    logic [LANE_W:0]   size_bytes;
    logic [LANE_W:0]   chunk_base;
    logic [LANE_W:0]   chunk_end;
    strb_t             exp_strb;
    logic              last_exp;
    logic              burst_end;

    assign w_hsk     = w_valid_i && w_ready_i;
    assign beat_take = w_hsk && desc_valid_i;

    // The first beat of a burst starts at the address offset in the bus word
    assign beat_idx = (state_q == BT_IDLE) ? '0 : beat_cnt_q;
    assign cur_lane = (state_q == BT_IDLE) ? desc_addr_i[LANE_W-1:0] : lane_q;

    // Sizes wider than the bus are treated as full width
    assign size_eff   = (desc_size_i > size_t'(LANE_W)) ? size_t'(LANE_W) : desc_size_i;
    assign size_bytes = {{LANE_W{1'b0}}, 1'b1} << size_eff;

    // Lanes of the size-aligned chunk that holds the running lane
    assign chunk_base = {1'b0, cur_lane} & ~(size_bytes - 1'b1);
    assign chunk_end  = chunk_base + size_bytes - 1'b1;
    assign next_lane  = chunk_base[LANE_W-1:0] + size_bytes[LANE_W-1:0];

    // Unaligned first beats only cover the lanes from the address upwards
    always_comb begin
        exp_strb = '0;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (((LANE_W+1)'(i) >= {1'b0, cur_lane}) && ((LANE_W+1)'(i) <= chunk_end)) begin
                exp_strb[i] = 1'b1;
            end
        end
    end

    // WLAST belongs exactly on beat index len
    assign last_exp  = (beat_idx == desc_len_i);
    assign burst_end = last_exp || w_last_i;

    assign no_aw_err_o  = w_hsk && !desc_valid_i;
    assign strb_err_o   = beat_take && (w_strb_i != exp_strb);
    assign wlast_err_o  = beat_take && (w_last_i != last_exp);
    assign burst_done_o = beat_take && burst_end;
    assign burst_ok_o   = burst_done_o && !err_seen_q && !strb_err_o && !wlast_err_o;

    always_comb begin
        state_d    = state_q;
        beat_cnt_d = beat_cnt_q;
        lane_d     = lane_q;
        err_seen_d = err_seen_q;
        if (beat_take) begin
            if (burst_end) begin
                state_d    = BT_IDLE;
                beat_cnt_d = '0;
                lane_d     = '0;
                err_seen_d = 1'b0;
            end else begin
                state_d    = BT_BURST;
                beat_cnt_d = beat_idx + 1'b1;
                lane_d     = next_lane;
                // A burst with any bad beat is not counted as completed
                err_seen_d = err_seen_q || strb_err_o || wlast_err_o;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= BT_IDLE;
            beat_cnt_q <= '0;
            lane_q     <= '0;
            err_seen_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            beat_cnt_q <= beat_cnt_d;
            lane_q     <= lane_d;
            err_seen_q <= err_seen_d;
        end
    end

    // The capture side must hold the open burst until its last beat
    a_beat_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == BT_BURST |-> desc_valid_i && (beat_cnt_q <= desc_len_i))
        else $error("beat_tracker beat index beyond burst length");

endmodule

`default_nettype wire

// ==== verilog/error_report.sv ====
// Error reporting for the write-path monitor
// Sticky flags, error and burst counters, and the outstanding B check
`timescale 1ns/1ns
`default_nettype none

`include "axi_mon_consts.svh"

module error_report (
    input  wire                                clk_i,
    input  wire                                rst_ni,
    input  wire                                b_valid_i,
    input  wire                                b_ready_i,
    input  wire                                overflow_i,
    input  wire                                no_aw_i,
    input  wire                                wlast_err_i,
    input  wire                                strb_err_i,
    input  wire                                burst_ok_i,
    input  wire                                burst_done_i,
    output logic [axi_mon_pkg::NUM_ERR-1:0]    err_flags_o,
    output logic [`ERR_CNT_W-1:0]              err_count_o,
    output logic [`ERR_CNT_W-1:0]              bursts_done_o
);

    import axi_mon_pkg::*;

    localparam int unsigned CNT_W   = `ERR_CNT_W;
    localparam int unsigned MAX_OUT = `MAX_OUTSTANDING;
    localparam int unsigned OUTST_W = $clog2(MAX_OUT + 1);
    localparam int unsigned EVT_W   = $clog2(NUM_ERR + 1);

    logic               b_hsk;
    logic               b_no_write;
    logic [OUTST_W-1:0] outst_q;
    logic [NUM_ERR-1:0] evt;
    logic [EVT_W-1:0]   evt_num;

    // A B response needs a finished burst still waiting for it
    assign b_hsk      = b_valid_i && b_ready_i;
    assign b_no_write = b_hsk && (outst_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outst_q <= '0;
        end else begin
            case ({burst_done_i, b_hsk && !b_no_write})
                2'b10:   outst_q <= outst_q + 1'b1;
                2'b01:   outst_q <= outst_q - 1'b1;
                default: outst_q <= outst_q;
            endcase
        end
    end

    // Strobes placed by error code, then counted
    always_comb begin
        evt                  = '0;
        evt[ERR_AW_OVERFLOW] = overflow_i;
        evt[ERR_W_NO_AW]     = no_aw_i;
        evt[ERR_WLAST]       = wlast_err_i;
        evt[ERR_STRB]        = strb_err_i;
        evt[ERR_B_NO_WRITE]  = b_no_write;
        evt_num              = '0;
        for (int i = 0; i < NUM_ERR; i++) begin
            evt_num = evt_num + EVT_W'(evt[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_flags_o   <= '0;
            err_count_o   <= '0;
            bursts_done_o <= '0;
        end else begin
            err_flags_o <= err_flags_o | evt;
            // Different errors in one cycle each count once
            err_count_o <= err_count_o + CNT_W'(evt_num);
            if (burst_ok_i) begin
                bursts_done_o <= bursts_done_o + 1'b1;
            end
        end
    end

    // The bus keeps the number of unanswered writes within the slave limit
    a_outst_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        outst_q <= MAX_OUT)
        else $error("error_report too many writes awaiting a response");

endmodule

`default_nettype wire

// ==== verilog/axi_write_monitor.sv ====
// Passive checker for the write path of a 64-bit AXI4 slave port
// Watches AW, W and B and reports protocol errors and completed bursts
`timescale 1ns/1ns
`default_nettype none

`include "axi_mon_consts.svh"

module axi_write_monitor (
    input  wire                                clk_i,
    input  wire                                rst_ni,
    input  wire                                aw_valid_i,
    input  wire                                aw_ready_i,
    input  wire  axi_mon_pkg::addr_t           aw_addr_i,
    input  wire  axi_mon_pkg::len_t            aw_len_i,
    input  wire  axi_mon_pkg::size_t           aw_size_i,
    input  wire                                w_valid_i,
    input  wire                                w_ready_i,
    input  wire  axi_mon_pkg::strb_t           w_strb_i,
    input  wire                                w_last_i,
    input  wire                                b_valid_i,
    input  wire                                b_ready_i,
    output logic [axi_mon_pkg::NUM_ERR-1:0]    err_flags_o,
    output logic [`ERR_CNT_W-1:0]              err_count_o,
    output logic [`ERR_CNT_W-1:0]              bursts_done_o
);

    import axi_mon_pkg::*;

    // Current burst descriptor from the AW side
    logic  desc_valid;
    addr_t desc_addr;
    len_t  desc_len;
    size_t desc_size;

    // Tracker result and one-cycle error strobes
    logic burst_done;
    logic overflow_evt;
    logic wlast_err_evt;
    logic strb_err_evt;
    logic no_aw_evt;
    logic burst_ok_evt;

    aw_capture i_aw_capture (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_i   (aw_ready_i),
        .aw_addr_i    (aw_addr_i),
        .aw_len_i     (aw_len_i),
        .aw_size_i    (aw_size_i),
        .burst_done_i (burst_done),
        .desc_valid_o (desc_valid),
        .desc_addr_o  (desc_addr),
        .desc_len_o   (desc_len),
        .desc_size_o  (desc_size),
        .overflow_o   (overflow_evt)
    );

    beat_tracker i_beat_tracker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .w_valid_i    (w_valid_i),
        .w_ready_i    (w_ready_i),
        .w_strb_i     (w_strb_i),
        .w_last_i     (w_last_i),
        .desc_valid_i (desc_valid),
        .desc_addr_i  (desc_addr),
        .desc_len_i   (desc_len),
        .desc_size_i  (desc_size),
        .burst_done_o (burst_done),
        .wlast_err_o  (wlast_err_evt),
        .strb_err_o   (strb_err_evt),
        .no_aw_err_o  (no_aw_evt),
        .burst_ok_o   (burst_ok_evt)
    );

    error_report i_error_report (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .b_valid_i     (b_valid_i),
        .b_ready_i     (b_ready_i),
        .overflow_i    (overflow_evt),
        .no_aw_i       (no_aw_evt),
        .wlast_err_i   (wlast_err_evt),
        .strb_err_i    (strb_err_evt),
        .burst_ok_i    (burst_ok_evt),
        .burst_done_i  (burst_done),
        .err_flags_o   (err_flags_o),
        .err_count_o   (err_count_o),
        .bursts_done_o (bursts_done_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_axi_write_monitor.sv ====
// Testbench for the AXI4 write-path monitor
// Random bursts with back-pressure, checked each cycle against a reference model
`timescale 1ns/1ns
`default_nettype none

`include "axi_mon_consts.svh"

module tb_axi_write_monitor;

    import axi_mon_pkg::*;

    localparam int LANES       = `AXI_STRB_W;
    localparam int FIFO_DEPTH  = `BURST_FIFO_DEPTH;
    localparam int RAND_BURSTS = 12;
    localparam int MAX_BEATS   = 16;
    // Random bursts at their longest plus the directed tests
    localparam int PLANNED_BEATS = RAND_BURSTS * MAX_BEATS + 100;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } burst_t;

    logic                          clk;
    logic                          rst_n;
    logic                          aw_valid;
    logic                          aw_ready;
    addr_t                         aw_addr;
    len_t                          aw_len;
    size_t                         aw_size;
    logic                          w_valid;
    logic                          w_ready;
    strb_t                         w_strb;
    logic                          w_last;
    logic                          b_valid;
    logic                          b_ready;
    logic [NUM_ERR-1:0]            err_flags;
    logic [`ERR_CNT_W-1:0]         err_count;
    logic [`ERR_CNT_W-1:0]         bursts_done;

    // Reference model state
    burst_t             m_queue[$];
    logic               m_in_burst;
    int                 m_beat;
    logic [2:0]         m_lane;
    logic               m_err_seen;
    int                 m_outst;
    logic [NUM_ERR-1:0] m_flags;
    int                 m_count;
    int                 m_bursts;

    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          checks;

    axi_write_monitor i_axi_write_monitor (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .aw_valid_i    (aw_valid),
        .aw_ready_i    (aw_ready),
        .aw_addr_i     (aw_addr),
        .aw_len_i      (aw_len),
        .aw_size_i     (aw_size),
        .w_valid_i     (w_valid),
        .w_ready_i     (w_ready),
        .w_strb_i      (w_strb),
        .w_last_i      (w_last),
        .b_valid_i     (b_valid),
        .b_ready_i     (b_ready),
        .err_flags_o   (err_flags),
        .err_count_o   (err_count),
        .bursts_done_o (bursts_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        repeat (PLANNED_BEATS * 20) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    // Xorshift generator with a fixed seed
    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // An INCR beat strobes the lanes from the running lane to the end of its chunk
    function automatic strb_t strobe_for(input logic [2:0] lane, input size_t size);
        int    bytes;
        int    first;
        int    base;
        strb_t s;
        bytes = 1 << ((size > 3) ? 3 : int'(size));
        first = int'(lane);
        base  = first - (first % bytes);
        s     = '0;
        for (int i = 0; i < LANES; i++) begin
            if (i >= first && i < base + bytes) begin
                s[i] = 1'b1;
            end
        end
        return s;
    endfunction

    // The next beat starts at the following chunk modulo the bus width
    function automatic logic [2:0] lane_after(input logic [2:0] lane, input size_t size);
        int bytes;
        int base;
        bytes = 1 << ((size > 3) ? 3 : int'(size));
        base  = int'(lane) - (int'(lane) % bytes);
        return 3'((base + bytes) % LANES);
    endfunction

    task automatic model_reset();
        m_queue.delete();
        m_in_burst = 1'b0;
        m_beat     = 0;
        m_lane     = '0;
        m_err_seen = 1'b0;
        m_outst    = 0;
        m_flags    = '0;
        m_count    = 0;
        m_bursts   = 0;
    endtask

    // Advances the model by one rising edge with the inputs held over that edge
    task automatic model_edge();
        logic   aw_hsk;
        logic   w_hsk;
        logic   b_hsk;
        logic   e_ovf;
        logic   e_noaw;
        logic   e_wlast;
        logic   e_strb;
        logic   e_b;
        logic   done;
        logic   ok;
        logic   last_exp;
        logic [2:0] lane;
        burst_t cur;
        int     idx;
        int     n;
        aw_hsk  = aw_valid && aw_ready;
        w_hsk   = w_valid && w_ready;
        b_hsk   = b_valid && b_ready;
        e_noaw  = 1'b0;
        e_wlast = 1'b0;
        e_strb  = 1'b0;
        done    = 1'b0;
        ok      = 1'b0;
        n       = m_queue.size();
        // An empty queue lets a burst accepted in this cycle serve the beat
        if (n != 0) begin
            cur = m_queue[0];
        end else begin
            cur = '{addr: aw_addr, len: aw_len, size: aw_size};
        end
        if (w_hsk && n == 0 && !aw_hsk) begin
            e_noaw = 1'b1;
        end else if (w_hsk) begin
            idx      = m_in_burst ? m_beat : 0;
            lane     = m_in_burst ? m_lane : cur.addr[2:0];
            last_exp = (idx == int'(cur.len));
            e_strb   = (w_strb != strobe_for(lane, cur.size));
            e_wlast  = (w_last != last_exp);
            done     = last_exp || w_last;
            if (done) begin
                ok         = !m_err_seen && !e_strb && !e_wlast;
                m_in_burst = 1'b0;
                m_beat     = 0;
                m_err_seen = 1'b0;
            end else begin
                m_in_burst = 1'b1;
                m_beat     = idx + 1;
                m_lane     = lane_after(lane, cur.size);
                m_err_seen = m_err_seen || e_strb || e_wlast;
            end
        end
        // Queue update uses the occupancy from before the edge
        e_ovf = aw_hsk && (n == FIFO_DEPTH);
        if (done && n != 0) begin
            void'(m_queue.pop_front());
        end
        if (aw_hsk && n != FIFO_DEPTH && !(n == 0 && done)) begin
            m_queue.push_back('{addr: aw_addr, len: aw_len, size: aw_size});
        end
        e_b = b_hsk && (m_outst == 0);
        if (done && !(b_hsk && !e_b)) begin
            m_outst++;
        end else if (!done && b_hsk && !e_b) begin
            m_outst--;
        end
        m_flags[ERR_AW_OVERFLOW] |= e_ovf;
        m_flags[ERR_W_NO_AW]     |= e_noaw;
        m_flags[ERR_WLAST]       |= e_wlast;
        m_flags[ERR_STRB]        |= e_strb;
        m_flags[ERR_B_NO_WRITE]  |= e_b;
        m_count += int'(e_ovf) + int'(e_noaw) + int'(e_wlast) + int'(e_strb) + int'(e_b);
        m_bursts += int'(ok);
    endtask

    task automatic check_value(input string what, input int unsigned expected,
                               input int unsigned actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic compare_model();
        check_value("err_flags", 32'(m_flags), 32'(err_flags));
        check_value("err_count", m_count, 32'(err_count));
        check_value("bursts_done", m_bursts, 32'(bursts_done));
    endtask

    // Called on a falling edge with the inputs already driven
    task automatic step();
        @(posedge clk);
        model_edge();
        @(negedge clk);
        compare_model();
    endtask

    task automatic idle_inputs();
        aw_valid = 1'b0;
        aw_ready = 1'b0;
        aw_addr  = '0;
        aw_len   = '0;
        aw_size  = '0;
        w_valid  = 1'b0;
        w_ready  = 1'b0;
        w_strb   = '0;
        w_last   = 1'b0;
        b_valid  = 1'b0;
        b_ready  = 1'b0;
    endtask

    task automatic apply_reset(input string name);
        test_name = name;
        idle_inputs();
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        model_reset();
        // Every output is cleared by reset
        check_value("err_flags after reset", 0, 32'(err_flags));
        check_value("err_count after reset", 0, 32'(err_count));
        check_value("bursts_done after reset", 0, 32'(bursts_done));
    endtask

    task automatic send_aw(input addr_t addr, input len_t len, input size_t size);
        logic hsk;
        aw_valid = 1'b1;
        aw_addr  = addr;
        aw_len   = len;
        aw_size  = size;
        do begin
            aw_ready = (rand_next() % 4) != 0;
            hsk      = aw_ready;
            step();
        end while (!hsk);
        aw_valid = 1'b0;
        aw_ready = 1'b0;
    endtask

    task automatic send_beat(input strb_t strb, input logic last);
        logic hsk;
        w_valid = 1'b1;
        w_strb  = strb;
        w_last  = last;
        do begin
            w_ready = (rand_next() % 4) != 0;
            hsk     = w_ready;
            step();
        end while (!hsk);
        w_valid = 1'b0;
        w_ready = 1'b0;
        w_last  = 1'b0;
    endtask

    task automatic send_b();
        logic hsk;
        b_valid = 1'b1;
        do begin
            b_ready = (rand_next() % 4) != 0;
            hsk     = b_ready;
            step();
        end while (!hsk);
        b_valid = 1'b0;
        b_ready = 1'b0;
    endtask

    // Beat flip_beat gets one strobe bit flipped and WLAST goes on beat last_at
    // (-1 leaves it out)
    task automatic write_beats(input addr_t addr, input len_t len, input size_t size,
                               input int flip_beat, input int last_at);
        logic [2:0] lane;
        strb_t      strb;
        lane = addr[2:0];
        for (int i = 0; i <= int'(len); i++) begin
            strb = strobe_for(lane, size);
            if (i == flip_beat) begin
                strb = strb ^ (strb_t'(1) << (rand_next() % LANES));
            end
            send_beat(strb, i == last_at);
            if (i == last_at) begin
                break;
            end
            lane = lane_after(lane, size);
        end
    endtask

    task automatic legal_aligned_bursts();
        size_t size;
        len_t  len;
        addr_t addr;
        apply_reset("legal_aligned");
        for (int b = 0; b < RAND_BURSTS; b++) begin
            size = size_t'(rand_next() % 4);
            len  = len_t'(rand_next() % MAX_BEATS);
            addr = rand_next() & ~((32'd1 << size) - 1);
            send_aw(addr, len, size);
            write_beats(addr, len, size, -1, int'(len));
            send_b();
        end
        // Single-beat burst whose AW and W complete in the same cycle
        aw_valid = 1'b1;
        aw_ready = 1'b1;
        aw_addr  = 32'h0000_1000;
        aw_len   = '0;
        aw_size  = 3'd3;
        w_valid  = 1'b1;
        w_ready  = 1'b1;
        w_strb   = 8'hff;
        w_last   = 1'b1;
        step();
        idle_inputs();
        send_b();
        check_value("flags of legal bursts", 0, 32'(err_flags));
        check_value("completed bursts", RAND_BURSTS + 1, 32'(bursts_done));
    endtask

    task automatic unaligned_strobe_bursts();
        size_t size;
        len_t  len;
        addr_t addr;
        apply_reset("unaligned_strobe");
        for (int b = 0; b < 5; b++) begin
            size = size_t'(1 + rand_next() % 3);
            len  = len_t'(rand_next() % 8);
            addr = {29'(rand_next() >> 3), 3'(((rand_next() % 4) * 2) + 1)};
            send_aw(addr, len, size);
            if (b < 4) begin
                write_beats(addr, len, size, -1, int'(len));
                check_value("flags of unaligned burst", 0, 32'(err_flags));
            end else begin
                write_beats(addr, len, size, int'(rand_next() % (len + 1)), int'(len));
                check_value("strobe flag", 1, 32'(err_flags[ERR_STRB]));
                // Only legal bursts came before, so the flipped bit is the one error
                check_value("count after bad strobe", 1, 32'(err_count));
            end
            send_b();
        end
    endtask

    task automatic early_and_missing_wlast();
        apply_reset("wlast_early");
        send_aw(32'h40, 8'd5, 3'd3);
        write_beats(32'h40, 8'd5, 3'd3, -1, 2);
        check_value("wlast flag", 1, 32'(err_flags[ERR_WLAST]));
        check_value("count after early wlast", 1, 32'(err_count));
        apply_reset("wlast_missing");
        send_aw(32'h84, 8'd3, 3'd2);
        write_beats(32'h84, 8'd3, 3'd2, -1, -1);
        check_value("wlast flag", 1, 32'(err_flags[ERR_WLAST]));
        check_value("completed bursts", 0, 32'(bursts_done));
    endtask

    task automatic w_before_aw_and_overflow();
        apply_reset("w_before_aw");
        send_beat(8'hff, 1'b1);
        // Flag is already set on the falling edge after the handshake edge
        check_value("no-AW flag", 1, 32'(err_flags[ERR_W_NO_AW]));
        apply_reset("aw_overflow");
        for (int b = 0; b <= FIFO_DEPTH; b++) begin
            send_aw(addr_t'(b * 64), 8'd1, 3'd3);
        end
        check_value("overflow flag", 1, 32'(err_flags[ERR_AW_OVERFLOW]));
        check_value("count after overflow", 1, 32'(err_count));
    endtask

    task automatic stray_b_response();
        apply_reset("b_response");
        for (int b = 0; b < 2; b++) begin
            send_aw(addr_t'(b * 32), 8'd1, 3'd2);
            write_beats(addr_t'(b * 32), 8'd1, 3'd2, -1, 1);
            send_b();
        end
        check_value("flags after legal responses", 0, 32'(err_flags));
        send_b();
        check_value("stray response flag", 1, 32'(err_flags[ERR_B_NO_WRITE]));
        check_value("count after stray response", 1, 32'(err_count));
    endtask

    initial begin
        rng_state = 32'hf762;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        idle_inputs();
        model_reset();
        legal_aligned_bursts();
        unaligned_strobe_bursts();
        early_and_missing_wlast();
        w_before_aw_and_overflow();
        stray_b_response();
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/axi_mon_pkg.sv
verilog/burst_fifo.sv
write_check/aw_capture.sv
write_check/beat_tracker.sv
verilog/error_report.sv
verilog/axi_write_monitor.sv
test/tb_axi_write_monitor.sv

// ==== Makefile ====
TOP := tb_axi_write_monitor

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

# The run passes only when the pass message shows up in the output
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
